// File: source/perf_pkg.sv
package perf_pkg;

	// event counter width, wraps modulo 2**COUNT_W
	localparam int COUNT_W = 12;

	// hex digits per counter word
	localparam int DIGITS = COUNT_W / 4;

	// one counter word, seen as a number or as hex digits
	typedef union packed {
		logic [COUNT_W-1:0]     value;    // arithmetic view
		logic [DIGITS-1:0][3:0] nibbles;  // [DIGITS-1] is the most significant digit
	} count_word_u;

	// report layout: letter, miss digits, access digits per group
	localparam int GROUP_LEN  = 1 + 2 * DIGITS;
	localparam int NUM_GROUPS = 3;
	localparam int REPORT_LEN = NUM_GROUPS * GROUP_LEN;  // 21 characters

	// group letters
	localparam logic [7:0] GROUP_CHAR_L1I = 8'h61;  // a
	localparam logic [7:0] GROUP_CHAR_L1D = 8'h62;  // b
	localparam logic [7:0] GROUP_CHAR_L2  = 8'h63;  // c

	// ascii bases for hex digit conversion
	localparam logic [7:0] ASCII_ZERO    = 8'h30;
	localparam logic [7:0] ASCII_UPPER_A = 8'h41;

endpackage

// File: source/event_edge_decode.sv
`timescale 1ns/1ps

module event_edge_decode (
	input  logic clk,
	input  logic rstn,
	input  logic read_l1i_i,
	input  logic miss_l1i_i,
	input  logic read_l1d_i,
	input  logic write_l1d_i,
	input  logic miss_l1d_i,
	input  logic read_l2_i,
	input  logic write_l2_i,
	input  logic miss_l2_i,
	input  logic report_req_i,
	output logic ev_l1i_rd_o,
	output logic ev_l1i_miss_o,
	output logic ev_l1d_rd_o,
	output logic ev_l1d_wr_o,
	output logic ev_l1d_miss_o,
	output logic ev_l2_rd_o,
	output logic ev_l2_wr_o,
	output logic ev_l2_miss_o,
	output logic req_pulse_o
);

	logic [8:0] lvl;
	logic [8:0] lvl_q;
	logic [8:0] rise;

	assign lvl = {report_req_i, miss_l2_i, write_l2_i, read_l2_i,
		miss_l1d_i, write_l1d_i, read_l1d_i, miss_l1i_i, read_l1i_i};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			lvl_q <= '0;
		end else begin
			lvl_q <= lvl;
		end
	end

	assign rise = lvl & ~lvl_q;  // high for one cycle per low-to-high change

	assign ev_l1i_rd_o   = rise[0];
	assign ev_l1i_miss_o = rise[1];
	assign ev_l1d_rd_o   = rise[2];
	assign ev_l1d_wr_o   = rise[3];
	assign ev_l1d_miss_o = rise[4];
	assign ev_l2_rd_o    = rise[5];
	assign ev_l2_wr_o    = rise[6];
	assign ev_l2_miss_o  = rise[7];
	assign req_pulse_o   = rise[8];

endmodule

// File: source/event_counters.sv
`timescale 1ns/1ps

module event_counters (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  ev_l1i_rd_i,
	input  logic                  ev_l1i_miss_i,
	input  logic                  ev_l1d_rd_i,
	input  logic                  ev_l1d_wr_i,
	input  logic                  ev_l1d_miss_i,
	input  logic                  ev_l2_rd_i,
	input  logic                  ev_l2_wr_i,
	input  logic                  ev_l2_miss_i,
	input  logic                  snap_i,
	output perf_pkg::count_word_u l1i_miss_o,
	output perf_pkg::count_word_u l1i_acc_o,
	output perf_pkg::count_word_u l1d_miss_o,
	output perf_pkg::count_word_u l1d_acc_o,
	output perf_pkg::count_word_u l2_miss_o,
	output perf_pkg::count_word_u l2_acc_o
);

	import perf_pkg::*;

	localparam int NUM_EV   = 8;
	localparam int L1I_RD   = 0;
	localparam int L1I_MISS = 1;
	localparam int L1D_RD   = 2;
	localparam int L1D_WR   = 3;
	localparam int L1D_MISS = 4;
	localparam int L2_RD    = 5;
	localparam int L2_WR    = 6;
	localparam int L2_MISS  = 7;

	logic [NUM_EV-1:0]              ev;
	logic [NUM_EV-1:0][COUNT_W-1:0] cnt;
	logic [NUM_EV-1:0][COUNT_W-1:0] cnt_nxt;
	count_word_u                    l1d_sum;
	count_word_u                    l2_sum;

	assign ev = {ev_l2_miss_i, ev_l2_wr_i, ev_l2_rd_i, ev_l1d_miss_i,
		ev_l1d_wr_i, ev_l1d_rd_i, ev_l1i_miss_i, ev_l1i_rd_i};

	always_comb begin
		for (int i = 0; i < NUM_EV; i++) begin
			cnt_nxt[i] = cnt[i] + COUNT_W'(ev[i]);  // wraps at 4096
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt <= '0;
		end else begin
			cnt <= cnt_nxt;
		end
	end

	// totals taken from the next values so a same-cycle event lands in the snapshot
	assign l1d_sum.value = cnt_nxt[L1D_RD] + cnt_nxt[L1D_WR];
	assign l2_sum.value  = cnt_nxt[L2_RD] + cnt_nxt[L2_WR];

	always_ff @(posedge clk) begin
		if (snap_i) begin
			l1i_miss_o.value <= cnt_nxt[L1I_MISS];
			l1i_acc_o.value  <= cnt_nxt[L1I_RD];
			l1d_miss_o.value <= cnt_nxt[L1D_MISS];
			l1d_acc_o        <= l1d_sum;
			l2_miss_o.value  <= cnt_nxt[L2_MISS];
			l2_acc_o         <= l2_sum;
		end
	end

endmodule

// File: source/report_formatter.sv
`timescale 1ns/1ps

module report_formatter (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  req_pulse_i,
	input  perf_pkg::count_word_u l1i_miss_i,
	input  perf_pkg::count_word_u l1i_acc_i,
	input  perf_pkg::count_word_u l1d_miss_i,
	input  perf_pkg::count_word_u l1d_acc_i,
	input  perf_pkg::count_word_u l2_miss_i,
	input  perf_pkg::count_word_u l2_acc_i,
	input  logic                  tx_busy_i,
	output logic                  snap_o,
	output logic                  report_busy_o,
	output logic                  tx_start_o,
	output logic [7:0]            tx_data_o
);

	import perf_pkg::*;

	localparam int IDX_W = $clog2(REPORT_LEN);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_SEND = 2'd1;  // wait for a free transmitter, then start
	localparam logic [1:0] S_WAIT = 2'd2;  // character on the line

	logic [1:0]       state;
	logic [IDX_W-1:0] idx;
	logic [1:0]       grp;
	logic [2:0]       pos;
	logic [1:0]       digit_sel;
	logic [3:0]       nibble;
	logic [7:0]       group_char;
	count_word_u      miss_word;
	count_word_u      acc_word;

	function automatic logic [7:0] hex_ascii(input logic [3:0] n);
		if (n < 4'd10) begin
			return ASCII_ZERO + 8'(n);
		end
		return ASCII_UPPER_A + 8'(n - 4'd10);
	endfunction

	// character index to group and position inside the group
	always_comb begin
		if (idx < IDX_W'(GROUP_LEN)) begin
			grp = 2'd0;
			pos = 3'(idx);
		end else if (idx < IDX_W'(2 * GROUP_LEN)) begin
			grp = 2'd1;
			pos = 3'(idx - IDX_W'(GROUP_LEN));
		end else begin
			grp = 2'd2;
			pos = 3'(idx - IDX_W'(2 * GROUP_LEN));
		end
	end

	always_comb begin
		case (grp)
			2'd0: begin
				group_char = GROUP_CHAR_L1I;
				miss_word  = l1i_miss_i;
				acc_word   = l1i_acc_i;
			end
			2'd1: begin
				group_char = GROUP_CHAR_L1D;
				miss_word  = l1d_miss_i;
				acc_word   = l1d_acc_i;
			end
			default: begin
				group_char = GROUP_CHAR_L2;
				miss_word  = l2_miss_i;
				acc_word   = l2_acc_i;
			end
		endcase
	end

	// miss digits first, then access digits, msd first
	always_comb begin
		if (pos == 3'd0) begin
			digit_sel = 2'd0;
			nibble    = 4'd0;
		end else if (pos <= 3'(DIGITS)) begin
			digit_sel = 2'(DIGITS - int'(pos));
			nibble    = miss_word.nibbles[digit_sel];
		end else begin
			digit_sel = 2'(2 * DIGITS - int'(pos));
			nibble    = acc_word.nibbles[digit_sel];
		end
	end

	assign tx_data_o     = (pos == 3'd0) ? group_char : hex_ascii(nibble);
	assign snap_o        = (state == S_IDLE) && req_pulse_i;
	assign tx_start_o    = (state == S_SEND) && !tx_busy_i;
	assign report_busy_o = (state != S_IDLE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= S_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (snap_o) begin
						state <= S_SEND;
						idx   <= '0;
					end
				end
				S_SEND: begin
					if (tx_start_o) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (!tx_busy_i) begin  // stop bit done
						if (idx == IDX_W'(REPORT_LEN - 1)) begin
							state <= S_IDLE;
						end else begin
							idx   <= idx + 1'b1;
							state <= S_SEND;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       start_i,
	input  logic [7:0] data_i,
	output logic       txd_o,
	output logic       busy_o
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;  // 0 start, 1..8 data, 9 stop
	logic [7:0]       shreg;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			txd_o   <= 1'b1;
			busy_o  <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy_o) begin
			txd_o <= 1'b1;
			if (start_i) begin
				txd_o   <= 1'b0;  // start bit
				busy_o  <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy_o <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == 4'd8) begin
					txd_o <= 1'b1;  // stop bit
				end else begin
					txd_o <= shreg[0];  // lsb first
				end
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (!busy_o && start_i) begin
			shreg <= data_i;
		end else if (busy_o && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && bit_idx < 4'd8) begin
			shreg <= shreg >> 1;
		end
	end

endmodule

// File: source/cache_perf_monitor.sv
`timescale 1ns/1ps

module cache_perf_monitor #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic clk,
	input  logic rstn,
	input  logic read_l1i_i,
	input  logic miss_l1i_i,
	input  logic read_l1d_i,
	input  logic write_l1d_i,
	input  logic miss_l1d_i,
	input  logic read_l2_i,
	input  logic write_l2_i,
	input  logic miss_l2_i,
	input  logic report_req_i,
	output logic txd_o,
	output logic report_busy_o
);

	import perf_pkg::*;

	logic        ev_l1i_rd;
	logic        ev_l1i_miss;
	logic        ev_l1d_rd;
	logic        ev_l1d_wr;
	logic        ev_l1d_miss;
	logic        ev_l2_rd;
	logic        ev_l2_wr;
	logic        ev_l2_miss;
	logic        req_pulse;
	logic        snap;
	logic        tx_start;
	logic        tx_busy;
	logic [7:0]  tx_data;
	count_word_u l1i_miss;
	count_word_u l1i_acc;
	count_word_u l1d_miss;
	count_word_u l1d_acc;
	count_word_u l2_miss;
	count_word_u l2_acc;

	event_edge_decode i_event_edge_decode (
		.clk           (clk),
		.rstn          (rstn),
		.read_l1i_i    (read_l1i_i),
		.miss_l1i_i    (miss_l1i_i),
		.read_l1d_i    (read_l1d_i),
		.write_l1d_i   (write_l1d_i),
		.miss_l1d_i    (miss_l1d_i),
		.read_l2_i     (read_l2_i),
		.write_l2_i    (write_l2_i),
		.miss_l2_i     (miss_l2_i),
		.report_req_i  (report_req_i),
		.ev_l1i_rd_o   (ev_l1i_rd),
		.ev_l1i_miss_o (ev_l1i_miss),
		.ev_l1d_rd_o   (ev_l1d_rd),
		.ev_l1d_wr_o   (ev_l1d_wr),
		.ev_l1d_miss_o (ev_l1d_miss),
		.ev_l2_rd_o    (ev_l2_rd),
		.ev_l2_wr_o    (ev_l2_wr),
		.ev_l2_miss_o  (ev_l2_miss),
		.req_pulse_o   (req_pulse)
	);

	event_counters i_event_counters (
		.clk           (clk),
		.rstn          (rstn),
		.ev_l1i_rd_i   (ev_l1i_rd),
		.ev_l1i_miss_i (ev_l1i_miss),
		.ev_l1d_rd_i   (ev_l1d_rd),
		.ev_l1d_wr_i   (ev_l1d_wr),
		.ev_l1d_miss_i (ev_l1d_miss),
		.ev_l2_rd_i    (ev_l2_rd),
		.ev_l2_wr_i    (ev_l2_wr),
		.ev_l2_miss_i  (ev_l2_miss),
		.snap_i        (snap),
		.l1i_miss_o    (l1i_miss),
		.l1i_acc_o     (l1i_acc),
		.l1d_miss_o    (l1d_miss),
		.l1d_acc_o     (l1d_acc),
		.l2_miss_o     (l2_miss),
		.l2_acc_o      (l2_acc)
	);

	report_formatter i_report_formatter (
		.clk           (clk),
		.rstn          (rstn),
		.req_pulse_i   (req_pulse),
		.l1i_miss_i    (l1i_miss),
		.l1i_acc_i     (l1i_acc),
		.l1d_miss_i    (l1d_miss),
		.l1d_acc_i     (l1d_acc),
		.l2_miss_i     (l2_miss),
		.l2_acc_i      (l2_acc),
		.tx_busy_i     (tx_busy),
		.snap_o        (snap),
		.report_busy_o (report_busy_o),
		.tx_start_o    (tx_start),
		.tx_data_o     (tx_data)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_tx (
		.clk     (clk),
		.rstn    (rstn),
		.start_i (tx_start),
		.data_i  (tx_data),
		.txd_o   (txd_o),
		.busy_o  (tx_busy)
	);

endmodule

// File: dv/cache_perf_monitor_properties.sv
`timescale 1ns/1ps

module cache_perf_monitor_properties (
	input logic clk,
	input logic rstn,
	input logic txd_o,
	input logic report_busy_o,
	input logic report_req_i
);

	// the line idles high outside a report
	line_idle_high: assert property (@(posedge clk) disable iff (!rstn)
		!report_busy_o |-> txd_o)
		else $error("txd_o low while no report is active");

	// busy rises one cycle after the request edge, never on its own
	busy_after_req: assert property (@(posedge clk) disable iff (!rstn)
		$rose(report_busy_o) |-> $past($rose(report_req_i)))
		else $error("report_busy_o rose without a request edge one cycle before");

	line_high_after_reset: assert property (@(posedge clk)
		$rose(rstn) |-> txd_o)
		else $error("txd_o not high in the first cycle after reset");

endmodule

// File: dv/cache_perf_monitor_tb.sv
`timescale 1ns/1ps

module cache_perf_monitor_tb;

	localparam int CLKS_PER_BIT = 8;
	localparam int REPORT_CHARS = 21;
	localparam int REPORTS      = 7;
	localparam int EVENT_CYCLES = 10000;  // wrap run, edge tests, idle gaps
	localparam int TIMEOUT      = 2 * (REPORTS * REPORT_CHARS * 10 * CLKS_PER_BIT + EVENT_CYCLES);

	logic       clk;
	logic       rstn;
	logic [7:0] ev_lvl;  // l1i rd, l1i miss, l1d rd, l1d wr, l1d miss, l2 rd, l2 wr, l2 miss
	logic       report_req;
	logic       txd_o;
	logic       report_busy_o;
	int         ref_cnt [8];
	logic [7:0] exp_chars [REPORT_CHARS];

	cache_perf_monitor #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_cache_perf_monitor (
		.clk           (clk),
		.rstn          (rstn),
		.read_l1i_i    (ev_lvl[0]),
		.miss_l1i_i    (ev_lvl[1]),
		.read_l1d_i    (ev_lvl[2]),
		.write_l1d_i   (ev_lvl[3]),
		.miss_l1d_i    (ev_lvl[4]),
		.read_l2_i     (ev_lvl[5]),
		.write_l2_i    (ev_lvl[6]),
		.miss_l2_i     (ev_lvl[7]),
		.report_req_i  (report_req),
		.txd_o         (txd_o),
		.report_busy_o (report_busy_o)
	);

	bind cache_perf_monitor cache_perf_monitor_properties i_properties (
		.clk           (clk),
		.rstn          (rstn),
		.txd_o         (txd_o),
		.report_busy_o (report_busy_o),
		.report_req_i  (report_req_i)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else stop_on_error($sformatf("[FAIL] %0t %s got 8'h%h expected 8'h%h",
			$time, name, got, exp));
	endtask

	function automatic logic [7:0] hex_char(input int v);
		return (v < 10) ? 8'h30 + 8'(v) : 8'h41 + 8'(v - 10);
	endfunction

	// expected text from the reference counters
	task automatic build_expected();
		int    words [6];
		string letters;
		letters  = "abc";
		words[0] = ref_cnt[1];
		words[1] = ref_cnt[0];
		words[2] = ref_cnt[4];
		words[3] = (ref_cnt[2] + ref_cnt[3]) % 4096;
		words[4] = ref_cnt[7];
		words[5] = (ref_cnt[5] + ref_cnt[6]) % 4096;
		for (int g = 0; g < 3; g++) begin
			exp_chars[g * 7] = letters[g];
			for (int d = 0; d < 3; d++) begin
				exp_chars[g * 7 + 1 + d] = hex_char((words[2 * g] >> (4 * (2 - d))) & 15);
				exp_chars[g * 7 + 4 + d] = hex_char((words[2 * g + 1] >> (4 * (2 - d))) & 15);
			end
		end
	endtask

	task automatic pulse_event(input int idx, input int n, input int hold);
		repeat (n) begin
			@(negedge clk);
			ev_lvl[idx] = 1'b1;
			repeat (hold) @(negedge clk);
			ev_lvl[idx] = 1'b0;
			ref_cnt[idx] = (ref_cnt[idx] + 1) % 4096;
		end
	endtask

	task automatic send_request();
		repeat (4) @(negedge clk);  // quiet gap before the trigger
		report_req = 1'b1;
		@(negedge clk);
		report_req = 1'b0;
	endtask

	// uart decoder, samples each bit near its middle
	task automatic receive_report();
		logic [7:0] ch;
		for (int i = 0; i < REPORT_CHARS; i++) begin
			@(negedge txd_o);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			check_value("txd_o start bit", {7'd0, txd_o}, 8'd0);
			for (int b = 0; b < 8; b++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				ch[b] = txd_o;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			check_value("txd_o stop bit", {7'd0, txd_o}, 8'd1);
			check_value($sformatf("txd_o char %0d", i), ch, exp_chars[i]);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (report_busy_o && n < 4 * CLKS_PER_BIT) begin
			@(negedge clk);
			n++;
		end
		assert (!report_busy_o) else stop_on_error("report_busy_o stayed high after the report");
	endtask

	task automatic run_report();
		build_expected();
		send_request();
		receive_report();
		wait_idle();
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("txd_o", {7'd0, txd_o}, 8'd1);
			check_value("report_busy_o", {7'd0, report_busy_o}, 8'd0);
		end
	endtask

	task automatic test_edges();
		pulse_event(0, 171, 1);  // 4 + 171 = 0AF
		pulse_event(1, 12, 4);   // held levels count once
		pulse_event(2, 20, 1);
		pulse_event(3, 10, 3);
		pulse_event(4, 13, 1);
		pulse_event(5, 7, 1);
		pulse_event(6, 4, 6);
		pulse_event(7, 15, 2);
		run_report();
	endtask

	task automatic test_random();
		int cnt [8];
		int max_cnt;
		repeat (2) begin
			max_cnt = 0;
			for (int i = 0; i < 8; i++) begin
				cnt[i] = $urandom_range(40, 1);
				if (cnt[i] > max_cnt) max_cnt = cnt[i];
			end
			for (int k = 0; k < max_cnt; k++) begin
				@(negedge clk);
				for (int i = 0; i < 8; i++) ev_lvl[i] = (k < cnt[i]);
				@(negedge clk);
				ev_lvl = '0;
			end
			for (int i = 0; i < 8; i++) ref_cnt[i] = (ref_cnt[i] + cnt[i]) % 4096;
			run_report();
		end
	endtask

	task automatic test_trigger_in_report();
		build_expected();
		send_request();
		fork
			receive_report();
			begin
				repeat (300) @(negedge clk);
				send_request();  // ignored while busy
				repeat (10) @(negedge clk);
				pulse_event(2, 5, 1);
				pulse_event(7, 3, 2);
			end
		join
		wait_idle();
		check_quiet(400);  // no second report
		run_report();
	endtask

	initial begin
		repeat (TIMEOUT) @(posedge clk);
		stop_on_error("timeout: the DUT did not finish the reports in time");
	end

	initial begin
		void'($urandom(32'h256e_e4b4));
		rstn       = 1'b0;
		ev_lvl     = '0;
		report_req = 1'b0;
		for (int i = 0; i < 8; i++) ref_cnt[i] = 0;
		repeat (2) @(negedge clk);
		rstn = 1'b1;
		check_quiet(200);
		run_report();            // empty report
		pulse_event(0, 4100, 1);
		run_report();            // l1i reads wrap to 004
		test_edges();
		test_random();
		test_trigger_in_report();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: all.f
source/perf_pkg.sv
source/event_edge_decode.sv
source/event_counters.sv
source/report_formatter.sv
source/uart_tx.sv
source/cache_perf_monitor.sv
dv/cache_perf_monitor_properties.sv
dv/cache_perf_monitor_tb.sv

// File: Bender.yml
package:
  name: cache_perf_monitor

sources:
  - source/perf_pkg.sv
  - source/event_edge_decode.sv
  - source/event_counters.sv
  - source/report_formatter.sv
  - source/uart_tx.sv
  - source/cache_perf_monitor.sv
  - target: test
    files:
      - dv/cache_perf_monitor_properties.sv
      - dv/cache_perf_monitor_tb.sv
